//--- rtl/tapper_pkg.sv
package tapper_pkg;

	localparam int lane_count = 4;

	typedef logic [9:0] coord_t;   // Horizontal position
	typedef logic [1:0] lane_t;
	typedef logic [7:0] score_t;
	typedef logic [3:0] speed_t;   // Extra customer step per tick
	typedef logic [6:0] seg_t;     // gfedcba, active low

	// Lane geometry
	localparam coord_t cus_min_x = 10'd60;
	localparam coord_t cus_max_x = 10'd380;   // Bar line, cups leave from here
	localparam int customer_w = 20;

	// Base customer step per lane
	localparam speed_t lane_step [lane_count] = '{4'd3, 4'd2, 4'd1, 4'd1};

	// Tick periods in clocks
	localparam int cup_delay = 2;
	localparam int customer_delay = 40;
	localparam int cup_cnt_w = $clog2(cup_delay);
	localparam int cus_cnt_w = $clog2(customer_delay);

	// Level progression
	localparam score_t level_goal = 8'd12;
	localparam score_t win_score = 8'd36;
	localparam speed_t level_speed [3] = '{4'd1, 4'd5, 4'd10};
	localparam logic [2:0] level_lights [3] = '{3'd1, 3'd3, 3'd7};

	typedef enum logic [2:0] {
		start1,
		play1,
		start2,
		play2,
		start3,
		play3,
		won,
		lost
	} game_state_t;

	// Digit patterns 0 to 9
	localparam seg_t seg_digits [10] = '{
		7'b1000000,
		7'b1111001,
		7'b0100100,
		7'b0110000,
		7'b0011001,
		7'b0010010,
		7'b0000010,
		7'b1111000,
		7'b0000000,
		7'b0010000
	};

endpackage

//--- rtl/player_ctrl.sv
`timescale 1ns/1ns

module player_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic [3:0]        key,
	input  logic              playing,
	output tapper_pkg::lane_t lane,
	output logic [3:0]        lane_onehot,
	output logic [3:0]        throw,
	output logic              start_press
);

	logic [3:0] key_prev;
	logic [3:0] key_fall;
	tapper_pkg::lane_t lane_next;

	// Keys are active low, so a press is a 1 to 0 step
	assign key_fall = key_prev & ~key;

	always_comb
	begin
		lane_next = lane;
		if (key_fall[2])
			lane_next = lane - 2'd1;   // Up, wraps 0 to 3
		else if (key_fall[3])
			lane_next = lane + 2'd1;   // Down, wraps 3 to 0
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			key_prev <= 4'b1111;
			lane <= '0;
			lane_onehot <= '0;
		end
		else
		begin
			key_prev <= key;
			lane <= lane_next;
			lane_onehot <= 4'b0001 << lane_next;   // Lights track the new lane
		end
	end

	// Key 0 serves as start in a pause and as throw during play
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			throw <= '0;
			start_press <= 1'b0;
		end
		else
		begin
			throw <= (key_fall[0] && playing) ? (4'b0001 << lane) : 4'b0000;
			start_press <= key_fall[0] && !playing;
		end
	end

endmodule

//--- rtl/lane_unit.sv
`timescale 1ns/1ns

module lane_unit #(
	parameter int lane_idx = 0
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               playing,
	input  logic               level_start,
	input  tapper_pkg::speed_t speed,
	input  logic               throw,
	output logic               served,
	output logic               reached
);

	logic [tapper_pkg::cup_cnt_w-1:0] cup_cnt;
	logic [tapper_pkg::cus_cnt_w-1:0] cus_cnt;
	logic cup_tick;
	logic cus_tick;
	tapper_pkg::coord_t cus_x;
	tapper_pkg::coord_t cup_x;
	tapper_pkg::coord_t cus_step;
	logic in_flight;
	logic hit;

	assign cup_tick = (cup_cnt == tapper_pkg::cup_delay - 1);
	assign cus_tick = (cus_cnt == tapper_pkg::customer_delay - 1);
	assign cus_step = tapper_pkg::coord_t'(tapper_pkg::lane_step[lane_idx])
		+ tapper_pkg::coord_t'(speed);

	// Cup has slid into the customer
	assign hit = in_flight && (cup_x <= cus_x + tapper_pkg::customer_w);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cup_cnt <= '0;
			cus_cnt <= '0;
			cus_x <= tapper_pkg::cus_min_x;
			cup_x <= tapper_pkg::cus_max_x;
			in_flight <= 1'b0;
			served <= 1'b0;
			reached <= 1'b0;
		end
		else
		begin
			served <= 1'b0;
			reached <= 1'b0;
			if (level_start)
			begin
				cup_cnt <= '0;
				cus_cnt <= '0;
				cus_x <= tapper_pkg::cus_min_x;
				cup_x <= tapper_pkg::cus_max_x;
				in_flight <= 1'b0;
			end
			else if (playing)
			begin
				cup_cnt <= cup_tick ? '0 : cup_cnt + 1'b1;
				cus_cnt <= cus_tick ? '0 : cus_cnt + 1'b1;

				if (in_flight && cup_tick)
					cup_x <= cup_x - 10'd1;
				if (throw && !in_flight)
					in_flight <= 1'b1;   // Cup leaves from the bar line

				if (hit)
				begin
					// Serve wins over any move in this cycle
					served <= 1'b1;
					in_flight <= 1'b0;
					cup_x <= tapper_pkg::cus_max_x;
					cus_x <= tapper_pkg::cus_min_x;
				end
				else if (cus_tick)
				begin
					if (cus_x >= tapper_pkg::cus_max_x)
					begin
						reached <= 1'b1;
						cus_x <= tapper_pkg::cus_min_x;
					end
					else
						cus_x <= cus_x + cus_step;
				end
			end
		end
	end

endmodule

//--- rtl/level_ctrl.sv
`timescale 1ns/1ns

module level_ctrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_press,
	input  logic [3:0]         served,
	input  logic [3:0]         reached,
	output logic               playing,
	output logic               level_start,
	output tapper_pkg::speed_t speed,
	output tapper_pkg::score_t score,
	output logic [2:0]         lights,
	output logic               won,
	output logic               lost
);

	tapper_pkg::game_state_t state;

	assign playing = (state == tapper_pkg::play1) || (state == tapper_pkg::play2)
		|| (state == tapper_pkg::play3);
	assign won = (state == tapper_pkg::won);
	assign lost = (state == tapper_pkg::lost);

	// Several lanes may serve in one cycle
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			score <= '0;
		else
			score <= score + tapper_pkg::score_t'($countones(served));
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= tapper_pkg::start1;
			level_start <= 1'b0;
			speed <= '0;
			lights <= '0;
		end
		else
		begin
			level_start <= 1'b0;
			if (playing && |reached)
				state <= tapper_pkg::lost;   // Customer got to the bar
			else
			begin
				case (state)
					tapper_pkg::start1:
						if (start_press)
						begin
							state <= tapper_pkg::play1;
							level_start <= 1'b1;
							speed <= tapper_pkg::level_speed[0];
							lights <= tapper_pkg::level_lights[0];
						end
					tapper_pkg::play1:
						if (score >= tapper_pkg::level_goal)
							state <= tapper_pkg::start2;
					tapper_pkg::start2:
						if (start_press)
						begin
							state <= tapper_pkg::play2;
							level_start <= 1'b1;
							speed <= tapper_pkg::level_speed[1];
							lights <= tapper_pkg::level_lights[1];
						end
					tapper_pkg::play2:
						if (score >= 2 * tapper_pkg::level_goal)
							state <= tapper_pkg::start3;
					tapper_pkg::start3:
						if (start_press)
						begin
							state <= tapper_pkg::play3;
							level_start <= 1'b1;
							speed <= tapper_pkg::level_speed[2];
							lights <= tapper_pkg::level_lights[2];
						end
					tapper_pkg::play3:
						if (score >= tapper_pkg::win_score)
							state <= tapper_pkg::won;
					default:
						state <= state;   // Won and lost hold until reset
				endcase
			end
		end
	end

endmodule

//--- rtl/score_display.sv
`timescale 1ns/1ns

module score_display (
	input  tapper_pkg::score_t score,
	output tapper_pkg::seg_t   hex0,
	output tapper_pkg::seg_t   hex1,
	output tapper_pkg::seg_t   hex2
);

	tapper_pkg::score_t rem;
	logic [3:0] hundreds;
	logic [3:0] tens;

	always_comb
	begin
		rem = score;
		hundreds = '0;
		tens = '0;
		// At most two hundreds in eight bits
		for (int i = 0; i < 2; i++)
		begin
			if (rem >= 8'd100)
			begin
				rem = rem - 8'd100;
				hundreds = hundreds + 4'd1;
			end
		end
		for (int i = 0; i < 9; i++)
		begin
			if (rem >= 8'd10)
			begin
				rem = rem - 8'd10;
				tens = tens + 4'd1;
			end
		end
	end

	assign hex0 = tapper_pkg::seg_digits[rem[3:0]];   // Units left over
	assign hex1 = tapper_pkg::seg_digits[tens];
	assign hex2 = tapper_pkg::seg_digits[hundreds];

endmodule

//--- rtl/tapper_top.sv
`timescale 1ns/1ns

module tapper_top (
	input  logic             clk,
	input  logic             rst,
	input  logic [3:0]       key,
	output tapper_pkg::seg_t hex0,
	output tapper_pkg::seg_t hex1,
	output tapper_pkg::seg_t hex2,
	output logic [9:0]       ledr
);

	logic [3:0] lane_onehot;
	logic [3:0] throw;
	logic start_press;
	logic playing;
	logic level_start;
	tapper_pkg::speed_t speed;
	tapper_pkg::score_t score;
	logic [2:0] lights;
	logic won;
	logic lost;
	logic [3:0] served;
	logic [3:0] reached;

	assign ledr = {lost, won, lane_onehot, 1'b0, lights};

	player_ctrl player_i (
		.clk         (clk),
		.rst         (rst),
		.key         (key),
		.playing     (playing),
		.lane        (),
		.lane_onehot (lane_onehot),
		.throw       (throw),
		.start_press (start_press)
	);

	for (genvar g = 0; g < tapper_pkg::lane_count; g++)
	begin : g_lane
		lane_unit #(.lane_idx(g)) lane_i (
			.clk         (clk),
			.rst         (rst),
			.playing     (playing),
			.level_start (level_start),
			.speed       (speed),
			.throw       (throw[g]),
			.served      (served[g]),
			.reached     (reached[g])
		);
	end

	level_ctrl level_i (
		.clk         (clk),
		.rst         (rst),
		.start_press (start_press),
		.served      (served),
		.reached     (reached),
		.playing     (playing),
		.level_start (level_start),
		.speed       (speed),
		.score       (score),
		.lights      (lights),
		.won         (won),
		.lost        (lost)
	);

	score_display display_i (
		.score (score),
		.hex0  (hex0),
		.hex1  (hex1),
		.hex2  (hex2)
	);

endmodule

//--- verif/tapper_assertions.sv
`timescale 1ns/1ns

module tapper_assertions (
	input logic               clk,
	input logic               rst,
	input logic               won,
	input logic               lost,
	input logic               level_start,
	input tapper_pkg::score_t score
);

	// End states hold until reset and never give way to each other
	won_holds: assert property (@(posedge clk) disable iff (!rst)
		won |=> won && !lost)
		else $error("won did not hold or lost rose after a win");

	lost_holds: assert property (@(posedge clk) disable iff (!rst)
		lost |=> lost && !won)
		else $error("lost did not hold or won rose after a loss");

	score_no_decrease: assert property (@(posedge clk) disable iff (!rst)
		score >= $past(score))
		else $error("score went down from %0d to %0d", $past(score), score);

	level_start_pulse: assert property (@(posedge clk) disable iff (!rst)
		level_start |=> !level_start)
		else $error("level_start held for more than one cycle");

endmodule

bind level_ctrl tapper_assertions assertions_i (
	.clk         (clk),
	.rst         (rst),
	.won         (won),
	.lost        (lost),
	.level_start (level_start),
	.score       (score)
);

//--- verif/tapper_tb.sv
`timescale 1ns/1ns

module tapper_tb;

	localparam int half_period = 20;
	// A cup alone crosses the whole lane in this many clocks
	localparam int serve_timeout = (int'(tapper_pkg::cus_max_x) - int'(tapper_pkg::cus_min_x))
		* tapper_pkg::cup_delay + 100;
	localparam int pause_cycles = 100;

	logic clk;
	logic rst;
	logic [3:0] key;
	tapper_pkg::seg_t hex0;
	tapper_pkg::seg_t hex1;
	tapper_pkg::seg_t hex2;
	logic [9:0] ledr;
	int cur_lane;   // Lane the player should be in
	int exp_score;
	int seed_ret;

	tapper_top tapper_top_i (
		.clk  (clk),
		.rst  (rst),
		.key  (key),
		.hex0 (hex0),
		.hex1 (hex1),
		.hex2 (hex2),
		.ledr (ledr)
	);

	always #half_period clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s expected %0d got %0d",
				$time, name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns waiting for %s", $time, what);
		$display(">>> FAIL");
		$fatal(1, "Wait limit exceeded");
	endtask

	function automatic int seg_value(input tapper_pkg::seg_t pattern);
		int value;
		value = -1;
		for (int d = 0; d < 10; d++)
			if (tapper_pkg::seg_digits[d] == pattern)
				value = d;
		return value;
	endfunction

	// Score read back from the digits, -1 for an unknown pattern
	function automatic int shown_score();
		int d0;
		int d1;
		int d2;
		d0 = seg_value(hex0);
		d1 = seg_value(hex1);
		d2 = seg_value(hex2);
		if (d0 < 0 || d1 < 0 || d2 < 0)
			return -1;
		return d2 * 100 + d1 * 10 + d0;
	endfunction

	task automatic check_display(input int expected);
		check_value("hex0", hex0, tapper_pkg::seg_digits[expected % 10]);
		check_value("hex1", hex1, tapper_pkg::seg_digits[(expected / 10) % 10]);
		check_value("hex2", hex2, tapper_pkg::seg_digits[expected / 100]);
	endtask

	task automatic wait_score(input int target);
		int cycles;
		cycles = 0;
		while (shown_score() < target && cycles < serve_timeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (shown_score() < target)
			report_timeout("the score to rise");
		else
		begin
			check_display(target);
			exp_score = target;
		end
	endtask

	task automatic wait_led(input int idx, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (ledr[idx] !== 1'b1 && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (ledr[idx] !== 1'b1)
			report_timeout(what);
	endtask

	task automatic apply_reset();
		rst = 1'b0;
		key = 4'hf;
		repeat (4) @(negedge clk);
		check_value("ledr", ledr, 10'd0);
		check_display(0);
		rst = 1'b1;
		@(negedge clk);
		check_value("ledr", ledr, 10'b0000010000);   // Lane 0 light only
		cur_lane = 0;
		exp_score = 0;
	endtask

	// Keys are active low, held for one cycle
	task automatic press_key(input int idx);
		key[idx] = 1'b0;
		@(negedge clk);
		key[idx] = 1'b1;
		@(negedge clk);
	endtask

	task automatic step_lane(input bit down);
		if (down)
		begin
			press_key(3);
			cur_lane = (cur_lane + 1) % tapper_pkg::lane_count;
		end
		else
		begin
			press_key(2);
			cur_lane = (cur_lane + tapper_pkg::lane_count - 1) % tapper_pkg::lane_count;
		end
		check_value("ledr[7:4]", ledr[7:4], 1 << cur_lane);
	endtask

	task automatic go_to_lane(input int target);
		while (cur_lane != target)
			step_lane(1'b1);
	endtask

	task automatic start_level(input logic [2:0] lights);
		press_key(0);
		check_value("ledr[2:0]", ledr[2:0], lights);
	endtask

	// One cup in every lane, all in flight together
	task automatic throw_burst();
		int base;
		base = exp_score;
		for (int i = 0; i < tapper_pkg::lane_count; i++)
		begin
			if (i > 0)
				step_lane(1'b1);
			press_key(0);
		end
		wait_score(base + tapper_pkg::lane_count);
	endtask

	task automatic hold_in_pause(input logic [2:0] lights);
		repeat (pause_cycles) @(negedge clk);
		check_value("ledr[2:0]", ledr[2:0], lights);
		check_value("ledr[9:8]", ledr[9:8], 2'b00);
		check_display(exp_score);
	endtask

	task automatic test_reset();
		apply_reset();
	endtask

	task automatic test_lane_select();
		start_level(tapper_pkg::level_lights[0]);
		repeat (3) step_lane(1'b1);
		repeat (3) step_lane(1'b0);
		step_lane(1'b0);   // 0 wraps to 3
		step_lane(1'b1);   // and back to 0
	endtask

	task automatic test_serves();
		for (int i = 0; i < 4; i++)
		begin
			go_to_lane($urandom_range(3, 0));
			press_key(0);
			wait_score(exp_score + 1);
			repeat (4 * tapper_pkg::cup_delay) @(negedge clk);
			check_display(exp_score);   // One throw, one serve
		end
		throw_burst();
	endtask

	task automatic test_levels();
		while (exp_score < tapper_pkg::level_goal)
			throw_burst();
		hold_in_pause(tapper_pkg::level_lights[0]);
		start_level(tapper_pkg::level_lights[1]);
		while (exp_score < 2 * tapper_pkg::level_goal)
			throw_burst();
		hold_in_pause(tapper_pkg::level_lights[1]);
		start_level(tapper_pkg::level_lights[2]);
	endtask

	task automatic test_win();
		while (exp_score < tapper_pkg::win_score)
			throw_burst();
		wait_led(8, 10, "the win light");
		check_display(tapper_pkg::win_score);
		check_value("ledr[9]", ledr[9], 1'b0);
	endtask

	task automatic test_loss();
		int range;
		int step;
		int ticks;
		int min_ticks;
		range = int'(tapper_pkg::cus_max_x) - int'(tapper_pkg::cus_min_x);
		min_ticks = 1 << 30;
		for (int l = 0; l < tapper_pkg::lane_count; l++)
		begin
			step = tapper_pkg::lane_step[l] + tapper_pkg::level_speed[0];
			ticks = (range + step - 1) / step + 1;   // Reach the bar, then one more tick
			if (ticks < min_ticks)
				min_ticks = ticks;
		end
		apply_reset();
		start_level(tapper_pkg::level_lights[0]);
		wait_led(9, (min_ticks + 2) * tapper_pkg::customer_delay, "the lost light");
		check_display(0);
		press_key(0);
		press_key(2);
		press_key(0);
		check_display(0);
		check_value("ledr[9:8]", ledr[9:8], 2'b10);
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b0;
		key = 4'hf;
		cur_lane = 0;
		exp_score = 0;
		seed_ret = $urandom(27);
		test_reset();
		test_lane_select();
		test_serves();
		test_levels();
		test_win();
		test_loss();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- files.f
rtl/tapper_pkg.sv
rtl/player_ctrl.sv
rtl/lane_unit.sv
rtl/level_ctrl.sv
rtl/score_display.sv
rtl/tapper_top.sv
verif/tapper_assertions.sv
verif/tapper_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tapper_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM ?= $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)
